/* sources.f */
hw/boot_pkg.sv
hw/rst_sync.sv
hw/spi_flash_reader.sv
hw/boot_ctrl.sv
hw/uart_tx.sv
hw/boot_mcu.sv
hw/board_wrapper.sv
dv/spi_flash_model.sv
dv/tb_board_wrapper.sv

/* run_sim.sh */
#!/bin/sh
# build and run the board wrapper testbench with Verilator
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps -Wno-fatal \
  -f sources.f --top-module tb_board_wrapper -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^TEST PASS$" "$LOG"; then
  exit 0
fi
exit 1

/* dv/tb_board_wrapper.sv */
// testbench for the board wrapper
// boots from a table of images, checks checksum, UART byte and flash traffic
`timescale 1ns/10ps

module tb_board_wrapper;
  import boot_pkg::*;

  localparam int unsigned N_TESTS = 4;
  localparam int unsigned LED_LEN = 4;
  localparam int unsigned XFER_CYCLES = 130;
  localparam int unsigned LED_CHECK_CYCLES = 32;
  localparam int unsigned CYCLE_LIMIT =
    N_TESTS * (BOOT_WORDS * XFER_CYCLES + 10 * CLKS_PER_BIT + 200);

  logic       clk_i = 1'b0;
  logic       rst_i;
  logic       fetch_enable_i;
  logic       boot_select_i;
  logic       rst_led_o;
  logic       clk_led_o;
  logic       clk_out_o;
  logic       uart_tx_o;
  logic       exit_value_o;
  logic       exit_valid_o;
  logic       spi_flash_cs_o;
  logic       spi_flash_clk_o;
  tri   [3:0] spi_flash_dio;

  logic [7:0]  image [0:511];
  logic        sel_tbl [N_TESTS] = '{1'b0, 1'b1, 1'b0, 1'b1};
  logic [31:0] sum_tbl [N_TESTS];
  int unsigned cycle_cnt = 0;
  int unsigned errors = 0;
  int unsigned failed = 0;

  always #20 clk_i = ~clk_i;

  board_wrapper #(.CLK_LED_COUNT_LENGTH(LED_LEN)) UUT (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .fetch_enable_i  (fetch_enable_i),
    .boot_select_i   (boot_select_i),
    .rst_led_o       (rst_led_o),
    .clk_led_o       (clk_led_o),
    .clk_out_o       (clk_out_o),
    .uart_tx_o       (uart_tx_o),
    .exit_value_o    (exit_value_o),
    .exit_valid_o    (exit_valid_o),
    .spi_flash_cs_o  (spi_flash_cs_o),
    .spi_flash_clk_o (spi_flash_clk_o),
    .spi_flash_dio_io(spi_flash_dio)
  );

  spi_flash_model u_flash (
    .cs_ni (spi_flash_cs_o),
    .sck_i (spi_flash_clk_o),
    .dio_io(spi_flash_dio)
  );

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout after %0d cycles, a boot did not finish", cycle_cnt);
      $display("TEST FAIL");
      $finish;
    end
  end

  // galois form, taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    logic [15:0] nxt;
    nxt = state >> 1;
    if (state[0]) begin
      nxt = nxt ^ 16'hB400;
    end
    return nxt;
  endfunction

  task automatic fill_flash();
    logic [15:0] lfsr;
    logic [7:0]  b;
    lfsr = 16'd25;
    b = '0;
    for (int a = 0; a < 512; a++) begin
      for (int k = 0; k < 8; k++) begin
        b = {b[6:0], lfsr[0]};
        lfsr = lfsr_next(lfsr);
      end
      image[a] = b;
      u_flash.load_byte(a, b);
    end
  endtask

  // flash words are big endian, sum wraps at 32 bits
  function automatic logic [31:0] image_sum(input logic sel);
    logic [31:0] sum;
    int unsigned a;
    sum = '0;
    for (int k = 0; k < BOOT_WORDS; k++) begin
      a = (sel ? BOOT_BASE_1 : BOOT_BASE_0) + 4 * k;
      sum = sum + {image[a], image[a + 1], image[a + 2], image[a + 3]};
    end
    return sum;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond) else begin
      $display("Error at %0t ns: %s", $time, what);
      errors++;
    end
  endtask

  task automatic end_test(input string name, input int unsigned err_before);
    if (errors == err_before) begin
      $display("test %s: passed", name);
    end else begin
      failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // samples near the middle of each bit, called on a falling clock edge
  task automatic receive_uart(output logic [7:0] data, output logic frame_ok);
    while (uart_tx_o !== 1'b0) @(negedge clk_i);
    repeat (CLKS_PER_BIT / 2) @(negedge clk_i);
    frame_ok = (uart_tx_o === 1'b0);
    for (int i = 0; i < 8; i++) begin
      repeat (CLKS_PER_BIT) @(negedge clk_i);
      data[i] = uart_tx_o;
    end
    repeat (CLKS_PER_BIT) @(negedge clk_i);
    frame_ok = frame_ok && (uart_tx_o === 1'b1);
  endtask

  task automatic run_boot(input int unsigned t);
    logic [7:0]        rx_byte;
    logic              frame_ok;
    int unsigned       hdr_base;
    int unsigned       err_before;
    logic [ADDR_W-1:0] base;
    logic [31:0]       exp_hdr;
    err_before = errors;
    hdr_base = u_flash.hdr_cnt;
    base = sel_tbl[t] ? BOOT_BASE_1 : BOOT_BASE_0;
    @(posedge clk_i);
    boot_select_i  <= sel_tbl[t];
    fetch_enable_i <= 1'b1;
    // old result drops once the synchronized edge is seen
    for (int i = 0; i < 8 && exit_valid_o; i++) @(negedge clk_i);
    check_true(!exit_valid_o, "exit_valid_o did not clear after fetch_enable_i rose");
    while (exit_valid_o !== 1'b1) @(negedge clk_i);
    check_value("exit_value_o", exit_value_o, sum_tbl[t][0]);
    receive_uart(rx_byte, frame_ok);
    check_value("uart_tx_o byte", rx_byte, sum_tbl[t][7:0]);
    check_true(frame_ok, "UART frame had a bad start or stop bit");
    check_value("exit_valid_o", exit_valid_o, 1'b1);
    check_true(u_flash.hdr_cnt == hdr_base + BOOT_WORDS,
               "flash did not see one read per boot word");
    for (int k = 0; k < BOOT_WORDS; k++) begin
      exp_hdr = {FLASH_CMD_READ, base + ADDR_W'(4 * k)};
      check_true(u_flash.hdr_log[(hdr_base + k) % 64] === exp_hdr,
                 $sformatf("flash read %0d got a wrong command or address", k));
    end
    @(posedge clk_i);
    fetch_enable_i <= 1'b0;
    repeat (2) @(posedge clk_i);
    end_test($sformatf("boot %0d select %0b", t, sel_tbl[t]), err_before);
  endtask

  initial begin
    int unsigned err_before;
    rst_i = 1'b1;
    fetch_enable_i = 1'b0;
    boot_select_i = 1'b0;
    fill_flash();
    for (int t = 0; t < N_TESTS; t++) begin
      sum_tbl[t] = image_sum(sel_tbl[t]);
    end

    err_before = errors;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_value("rst_led_o", rst_led_o, 1'b0);
    @(posedge clk_i);
    rst_i <= 1'b0;

    // internal reset lifts on the second edge after the board reset drops
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    check_value("exit_valid_o", exit_valid_o, 1'b0);
    check_value("spi_flash_cs_o", spi_flash_cs_o, 1'b1);
    check_value("spi_flash_clk_o", spi_flash_clk_o, 1'b0);
    check_value("uart_tx_o", uart_tx_o, 1'b1);
    check_value("rst_led_o", rst_led_o, 1'b1);
    check_value("clk_led_o", clk_led_o, 1'b0);
    end_test("reset values", err_before);

    // first release cycle counts as heartbeat count zero
    err_before = errors;
    for (int n = 0; n < LED_CHECK_CYCLES; n++) begin
      check_value("clk_led_o", clk_led_o, (n >> (LED_LEN - 1)) & 1);
      @(posedge clk_i);
      #1;
      check_value("clk_out_o", clk_out_o, clk_i);
      @(negedge clk_i);
      #1;
      check_value("clk_out_o", clk_out_o, clk_i);
    end
    end_test("heartbeat and debug clock", err_before);

    for (int t = 0; t < N_TESTS; t++) begin
      run_boot(t);
    end

    $display("tests %0d, failed %0d, errors %0d", N_TESTS + 2, failed, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* dv/spi_flash_model.sv */
// behavioral SPI serial flash
// answers the single lane read command from a 512-byte array, pull-ups on all lanes
`timescale 1ns/10ps

module spi_flash_model (
  input  logic     cs_ni,
  input  logic     sck_i,
  inout  tri [3:0] dio_io
);

  logic [7:0]  mem [0:511];
  logic [31:0] hdr_log [0:63];
  int unsigned hdr_cnt = 0;
  logic [5:0]  rx_cnt = '0;
  logic [4:0]  tx_idx = 5'd31;
  logic [31:0] hdr_q;
  logic [31:0] word_q;
  logic        miso_q = 1'b1;
  logic        miso_en_q = 1'b0;

  for (genvar i = 0; i < 4; i++) begin : g_pull
    pullup (dio_io[i]);
  end

  // lane 1 carries read data, released outside the data phase
  assign dio_io[1] = miso_en_q ? miso_q : 1'bz;

  task automatic load_byte(input int unsigned addr, input logic [7:0] val);
    mem[addr] = val;
  endtask

  // bytes leave in ascending address order, msb first
  function automatic logic [31:0] mem_word(input logic [23:0] addr);
    logic [8:0] a;
    a = addr[8:0];
    return {mem[a], mem[a + 9'd1], mem[a + 9'd2], mem[a + 9'd3]};
  endfunction

  // opcode and address arrive on lane 0, sampled on rising sck
  always @(posedge sck_i or posedge cs_ni) begin
    if (cs_ni) begin
      rx_cnt <= '0;
    end else if (rx_cnt < 6'd32) begin
      hdr_q  <= {hdr_q[30:0], dio_io[0]};
      rx_cnt <= rx_cnt + 6'd1;
      if (rx_cnt == 6'd31) begin
        word_q                 <= mem_word({hdr_q[22:0], dio_io[0]});
        hdr_log[hdr_cnt % 64] <= {hdr_q[30:0], dio_io[0]};
        hdr_cnt                <= hdr_cnt + 1;
      end
    end
  end

  // data changes on falling sck once the header is complete
  always @(negedge sck_i or posedge cs_ni) begin
    if (cs_ni) begin
      miso_en_q <= 1'b0;
      tx_idx    <= 5'd31;
    end else if (rx_cnt == 6'd32) begin
      miso_q    <= word_q[tx_idx];
      miso_en_q <= 1'b1;
      tx_idx    <= tx_idx - 5'd1;
    end
  end

endmodule

/* hw/board_wrapper.sv */
// FPGA board top level
// reset sync, heartbeat LED, QSPI pads and the boot checking core
`timescale 1ns/10ps

module board_wrapper #(
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     fetch_enable_i,
  input  logic     boot_select_i,
  output logic     rst_led_o,
  output logic     clk_led_o,
  output logic     clk_out_o,
  output logic     uart_tx_o,
  output logic     exit_value_o,
  output logic     exit_valid_o,
  output logic     spi_flash_cs_o,
  output logic     spi_flash_clk_o,
  inout  tri [3:0] spi_flash_dio_io
);
  import boot_pkg::*;

  logic                            clk_gen;
  logic                            rst_ni;
  logic [DATA_W-1:0]               exit_value;
  logic [3:0]                      flash_di;
  logic [3:0]                      flash_do;
  logic [3:0]                      flash_oe;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count_q;

  // no clock wizard on this board, input clock used as is
  assign clk_gen = clk_i;

  rst_sync u_rst_sync (
    .clk_gen(clk_gen),
    .rst_i  (rst_i),
    .rst_no (rst_ni)
  );

  assign rst_led_o = rst_ni;

  // heartbeat
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      clk_count_q <= '0;
    end else begin
      clk_count_q <= clk_count_q + 1'b1;
    end
  end

  assign clk_led_o = clk_count_q[CLK_LED_COUNT_LENGTH-1];

  // debug clock out
  assign clk_out_o = clk_gen;

  // behavioral tristate pads, one per QSPI data lane
  for (genvar i = 0; i < 4; i++) begin : g_qspi_pad
    assign spi_flash_dio_io[i] = flash_oe[i] ? flash_do[i] : 1'bz;
    assign flash_di[i]         = spi_flash_dio_io[i];
  end

  boot_mcu u_boot_mcu (
    .clk_gen       (clk_gen),
    .rst_ni        (rst_ni),
    .fetch_enable_i(fetch_enable_i),
    .boot_select_i (boot_select_i),
    .flash_di_i    (flash_di),
    .flash_do_o    (flash_do),
    .flash_oe_o    (flash_oe),
    .flash_cs_no   (spi_flash_cs_o),
    .flash_sck_o   (spi_flash_clk_o),
    .uart_tx_o     (uart_tx_o),
    .exit_value_o  (exit_value),
    .exit_valid_o  (exit_valid_o)
  );

  // only the checksum lsb reaches a pin
  assign exit_value_o = exit_value[0];

endmodule

/* hw/boot_mcu.sv */
// boot checking core
// boot sequencer, single lane flash reader and uart on one QSPI port
`timescale 1ns/10ps

module boot_mcu (
  input  logic                        clk_gen,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  input  logic                        boot_select_i,
  input  logic [3:0]                  flash_di_i,
  output logic [3:0]                  flash_do_o,
  output logic [3:0]                  flash_oe_o,
  output logic                        flash_cs_no,
  output logic                        flash_sck_o,
  output logic                        uart_tx_o,
  output logic [boot_pkg::DATA_W-1:0] exit_value_o,
  output logic                        exit_valid_o
);
  import boot_pkg::*;

  logic              rd_start;
  logic              rd_done;
  logic [ADDR_W-1:0] rd_addr;
  logic [DATA_W-1:0] rd_data;
  logic              tx_start;
  logic              tx_busy;
  logic [7:0]        tx_byte;
  logic              lane0_do;
  logic              lane0_oe;

  // lane 0 is MOSI, lane 1 is MISO, quad lanes stay tied off
  assign flash_do_o = {3'b000, lane0_do};
  assign flash_oe_o = {3'b000, lane0_oe};

  boot_ctrl u_boot_ctrl (
    .clk_gen       (clk_gen),
    .rst_ni        (rst_ni),
    .fetch_enable_i(fetch_enable_i),
    .boot_select_i (boot_select_i),
    .rd_done_i     (rd_done),
    .rd_data_i     (rd_data),
    .tx_busy_i     (tx_busy),
    .rd_start_o    (rd_start),
    .rd_addr_o     (rd_addr),
    .exit_value_o  (exit_value_o),
    .exit_valid_o  (exit_valid_o),
    .tx_start_o    (tx_start),
    .tx_byte_o     (tx_byte)
  );

  spi_flash_reader u_spi_flash_reader (
    .clk_gen    (clk_gen),
    .rst_ni     (rst_ni),
    .start_i    (rd_start),
    .addr_i     (rd_addr),
    .data_o     (rd_data),
    .done_o     (rd_done),
    .flash_cs_no(flash_cs_no),
    .flash_sck_o(flash_sck_o),
    .flash_do_o (lane0_do),
    .flash_oe_o (lane0_oe),
    .flash_di_i (flash_di_i[1])
  );

  uart_tx u_uart_tx (
    .clk_gen(clk_gen),
    .rst_ni (rst_ni),
    .start_i(tx_start),
    .byte_i (tx_byte),
    .busy_o (tx_busy),
    .tx_o   (uart_tx_o)
  );

endmodule

/* hw/uart_tx.sv */
// uart transmitter, 8N1
// sends one byte per start pulse, busy covers start to end of stop bit
`timescale 1ns/10ps

module uart_tx (
  input  logic       clk_gen,
  input  logic       rst_ni,
  input  logic       start_i,
  input  logic [7:0] byte_i,
  output logic       busy_o,
  output logic       tx_o
);
  import boot_pkg::*;

  logic [BAUD_CNT_W-1:0]   baud_cnt_q;
  logic [FRAME_CNT_W-1:0]  bit_cnt_q;
  logic [UART_FRAME_W-2:0] shift_q;
  logic                    bit_end;

  assign bit_end = baud_cnt_q == BAUD_CNT_W'(CLKS_PER_BIT - 1);

  // start bit goes out right away, the rest of the frame waits in shift_q
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_o     <= 1'b0;
      tx_o       <= 1'b1;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
    end else if (!busy_o) begin
      if (start_i) begin
        busy_o     <= 1'b1;
        tx_o       <= 1'b0;
        baud_cnt_q <= '0;
        bit_cnt_q  <= '0;
      end
    end else if (bit_end) begin
      baud_cnt_q <= '0;
      if (bit_cnt_q == FRAME_CNT_W'(UART_FRAME_W - 1)) begin
        busy_o <= 1'b0;
        tx_o   <= 1'b1;
      end else begin
        tx_o      <= shift_q[0];
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
    end else begin
      baud_cnt_q <= baud_cnt_q + 1'b1;
    end
  end

  // data lsb first, stop bit on top
  always_ff @(posedge clk_gen) begin
    if (!busy_o && start_i) begin
      shift_q <= {1'b1, byte_i};
    end else if (busy_o && bit_end) begin
      shift_q <= shift_q >> 1;
    end
  end

  // idle line
  a_idle_high : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    !busy_o |-> tx_o);

endmodule

/* hw/boot_ctrl.sv */
// boot sequencer
// reads the boot image word by word and sums it into the exit value
`timescale 1ns/10ps

module boot_ctrl (
  input  logic                        clk_gen,
  input  logic                        rst_ni,
  input  logic                        fetch_enable_i,
  input  logic                        boot_select_i,
  input  logic                        rd_done_i,
  input  logic [boot_pkg::DATA_W-1:0] rd_data_i,
  input  logic                        tx_busy_i,
  output logic                        rd_start_o,
  output logic [boot_pkg::ADDR_W-1:0] rd_addr_o,
  output logic [boot_pkg::DATA_W-1:0] exit_value_o,
  output logic                        exit_valid_o,
  output logic                        tx_start_o,
  output logic [7:0]                  tx_byte_o
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_FINISH
  } state_e;

  state_e                state_q;
  logic [1:0]            fetch_q;
  logic                  fetch_rise;
  logic                  boot_sel_q;
  logic [WORD_CNT_W-1:0] word_cnt_q;
  logic [DATA_W-1:0]     sum_q;
  logic [ADDR_W-1:0]     base;
  logic                  rd_pending_q;

  // fetch enable is asynchronous to the core, two flops before the edge
  assign fetch_rise = fetch_q[0] & ~fetch_q[1];

  assign base         = boot_sel_q ? BOOT_BASE_1 : BOOT_BASE_0;
  assign rd_addr_o    = base + (ADDR_W'(word_cnt_q) << 2);
  assign exit_value_o = sum_q;
  assign tx_byte_o    = sum_q[7:0];

  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ST_IDLE;
      fetch_q      <= 2'b00;
      boot_sel_q   <= 1'b0;
      word_cnt_q   <= '0;
      sum_q        <= '0;
      exit_valid_o <= 1'b0;
      rd_start_o   <= 1'b0;
      tx_start_o   <= 1'b0;
    end else begin
      fetch_q    <= {fetch_q[0], fetch_enable_i};
      rd_start_o <= 1'b0;
      tx_start_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (fetch_rise) begin
            boot_sel_q   <= boot_select_i;
            word_cnt_q   <= '0;
            sum_q        <= '0;
            exit_valid_o <= 1'b0;
            state_q      <= ST_READ;
          end
        end
        ST_READ: begin
          rd_start_o <= 1'b1;
          state_q    <= ST_WAIT;
        end
        ST_WAIT: begin
          if (rd_done_i) begin
            sum_q <= sum_q + rd_data_i;
            if (word_cnt_q == WORD_CNT_W'(BOOT_WORDS - 1)) begin
              exit_valid_o <= 1'b1;
              state_q      <= ST_FINISH;
            end else begin
              word_cnt_q <= word_cnt_q + 1'b1;
              state_q    <= ST_READ;
            end
          end
        end
        ST_FINISH: begin
          // report the low byte once the uart is free
          if (!tx_busy_i) begin
            tx_start_o <= 1'b1;
            state_q    <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // tracks an open read on the reader side
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pending_q <= 1'b0;
    end else if (rd_start_o) begin
      rd_pending_q <= 1'b1;
    end else if (rd_done_i) begin
      rd_pending_q <= 1'b0;
    end
  end

  a_no_overlap_rd : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    rd_start_o |-> !rd_pending_q);

  a_tx_when_free : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    tx_start_o |-> !tx_busy_i);

endmodule

/* hw/spi_flash_reader.sv */
// single lane SPI flash word reader
// sends read opcode and address, then shifts in one 32-bit word, mode 0
`timescale 1ns/10ps

module spi_flash_reader (
  input  logic                        clk_gen,
  input  logic                        rst_ni,
  input  logic                        start_i,
  input  logic [boot_pkg::ADDR_W-1:0] addr_i,
  output logic [boot_pkg::DATA_W-1:0] data_o,
  output logic                        done_o,
  output logic                        flash_cs_no,
  output logic                        flash_sck_o,
  output logic                        flash_do_o,
  output logic                        flash_oe_o,
  input  logic                        flash_di_i
);
  import boot_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_XFER,
    ST_END
  } state_e;

  state_e                state_q;
  logic [XFER_CNT_W-1:0] bit_cnt_q;
  logic [DATA_W-1:0]     sreg_q;
  logic                  out_phase;
  logic                  launch;

  assign launch    = (state_q == ST_IDLE) && start_i;
  assign out_phase = bit_cnt_q < XFER_CNT_W'(HDR_BITS);

  // sck toggles every cycle, bit counter steps on the falling edge
  always_ff @(posedge clk_gen or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= ST_IDLE;
      bit_cnt_q   <= '0;
      flash_cs_no <= 1'b1;
      flash_sck_o <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (start_i) begin
            state_q     <= ST_XFER;
            bit_cnt_q   <= '0;
            flash_cs_no <= 1'b0;
          end
        end
        ST_XFER: begin
          flash_sck_o <= ~flash_sck_o;
          if (flash_sck_o) begin
            if (bit_cnt_q == XFER_CNT_W'(XFER_BITS - 1)) begin
              flash_cs_no <= 1'b1;
              state_q     <= ST_END;
            end else begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
            end
          end
        end
        ST_END: begin
          done_o  <= 1'b1;
          state_q <= ST_IDLE;
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // one shift register serves both directions
  // header leaves msb first on falling sck, data enters lsb side on rising sck
  always_ff @(posedge clk_gen) begin
    if (launch) begin
      sreg_q <= {FLASH_CMD_READ, addr_i};
    end else if (state_q == ST_XFER) begin
      if (flash_sck_o && out_phase) begin
        sreg_q <= sreg_q << 1;
      end else if (!flash_sck_o && !out_phase) begin
        sreg_q <= {sreg_q[DATA_W-2:0], flash_di_i};
      end
    end
  end

  assign flash_do_o = sreg_q[DATA_W-1];
  assign flash_oe_o = (state_q == ST_XFER) && out_phase;
  assign data_o     = sreg_q;

  // chip select never low outside a transfer
  a_cs_in_xfer : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    !flash_cs_no |-> state_q == ST_XFER);

  // fixed latency from accepted start to done
  a_xfer_latency : assert property (@(posedge clk_gen) disable iff (!rst_ni)
    launch |-> ##(2 * XFER_BITS + 2) done_o);

endmodule

/* hw/rst_sync.sv */
// reset synchronizer
// board reset asserts at once, internal reset releases after two clock edges
`timescale 1ns/10ps

module rst_sync (
  input  logic clk_gen,
  input  logic rst_i,
  output logic rst_no
);

  logic [1:0] sync_q;

  // ones ripple in once the board reset is gone
  always_ff @(posedge clk_gen or posedge rst_i) begin
    if (rst_i) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_no = sync_q[1];

endmodule

/* hw/boot_pkg.sv */
// boot checker shared constants
// flash command, bus widths, boot image layout and UART bit timing
package boot_pkg;

  // serial flash read command, single lane
  localparam int unsigned CMD_W = 8;
  localparam logic [CMD_W-1:0] FLASH_CMD_READ = 8'h03;

  localparam int unsigned ADDR_W = 24;
  localparam int unsigned DATA_W = 32;

  // command plus address fits exactly one data word
  localparam int unsigned HDR_BITS = CMD_W + ADDR_W;
  localparam int unsigned XFER_BITS = CMD_W + ADDR_W + DATA_W;
  localparam int unsigned XFER_CNT_W = $clog2(XFER_BITS);

  // boot image layout
  localparam int unsigned BOOT_WORDS = 4;
  localparam int unsigned WORD_CNT_W = $clog2(BOOT_WORDS);
  localparam logic [ADDR_W-1:0] BOOT_BASE_0 = 24'h000000;
  localparam logic [ADDR_W-1:0] BOOT_BASE_1 = 24'h000100;

  // uart 8N1, small divider for simulation
  localparam int unsigned CLKS_PER_BIT = 8;
  localparam int unsigned BAUD_CNT_W = $clog2(CLKS_PER_BIT);
  localparam int unsigned UART_FRAME_W = 10;
  localparam int unsigned FRAME_CNT_W = $clog2(UART_FRAME_W);

endpackage
